// File: mem_pkg.sv
package mem_pkg;

    // data path width
    localparam int XLEN = 32;
    localparam int NUM_LANES = XLEN / 8;   // byte lanes per word

    typedef logic [XLEN-1:0] uint_x;

    // instruction id, tells back-to-back instructions apart
    typedef logic [7:0] iid_t;

    // memory access kind
    typedef enum logic [1:0] {
        MEN_X  = 2'd0,   // no access
        MEN_S  = 2'd1,   // store
        MEN_LS = 2'd2,   // signed load
        MEN_LU = 2'd3    // unsigned load
    } mem_sel_t;

    // access size
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2
    } mem_size_t;

    // memory part of the decoded control word
    typedef struct packed {
        mem_sel_t  mem_wen;
        mem_size_t mem_size;
    } mem_ctrl_t;

    // saved id after reset so the first instruction counts as new
    localparam iid_t IID_RANDOM = 8'ha5;

    // data RAM geometry
    localparam int RAM_DEPTH = 256;   // words
    localparam int RAM_AW = 8;        // word address, taken from addr[9:2]

    // accept edge to response pulse
    localparam int LOAD_LATENCY = 2;
    localparam int LAT_W = $clog2(LOAD_LATENCY + 1);

endpackage

// File: data_req_if.sv
`timescale 1ns/1ns

// request channel from the memory stage to the memory unit
interface data_req_if import mem_pkg::*; ();

    logic      valid;
    logic      ready;
    logic      wen;     // 1 = store
    uint_x     addr;
    uint_x     wdata;
    mem_size_t wmask;   // access size

    modport stage (
        output valid, wen, addr, wdata, wmask,
        input  ready
    );

    modport unit (
        input  valid, wen, addr, wdata, wmask,
        output ready
    );

endinterface

// File: data_ram.sv
`timescale 1ns/1ns

module data_ram import mem_pkg::*; (
    input  logic                 clk,
    input  logic                 en,
    input  logic [NUM_LANES-1:0] we,      // per-byte write enables
    input  logic [RAM_AW-1:0]    addr,
    input  uint_x                wdata,
    output uint_x                rdata
);

    uint_x mem [RAM_DEPTH];

    // write at the edge, read data one cycle later
    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                if (we[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
            rdata <= mem[addr];   // old word on a write
        end
    end

endmodule

// File: memory_unit.sv
`timescale 1ns/1ns

module memory_unit import mem_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,

    data_req_if.unit             dreq,

    // response to the stage
    output logic                 resp_valid,
    output uint_x                resp_rdata,

    // data RAM side
    output logic                 ram_en,
    output logic [NUM_LANES-1:0] ram_we,
    output logic [RAM_AW-1:0]    ram_addr,
    output uint_x                ram_wdata,
    input  uint_x                ram_rdata
);

    logic                 accept;
    logic                 load_accept;
    logic                 load_busy;
    logic                 load_done;
    logic [LAT_W-1:0]     lat_cnt;
    logic [1:0]           byte_off;
    logic [1:0]           load_off;    // byte offset of the pending load
    logic [NUM_LANES-1:0] lane_mask;

    assign dreq.ready  = !load_busy;   // only one load in flight
    assign accept      = dreq.valid && dreq.ready;
    assign load_accept = accept && !dreq.wen;
    assign byte_off    = dreq.addr[1:0];

    // last count of the latency window
    assign load_done = load_busy && (lat_cnt == LAT_W'(1));

    // byte enables from size and low address bits
    always_comb begin
        case (dreq.wmask)
            SIZE_B:  lane_mask = 4'b0001 << byte_off;
            SIZE_H:  lane_mask = 4'b0011 << byte_off;
            default: lane_mask = 4'b1111;
        endcase
    end

    // copy store data into every lane, the enables pick the right one
    always_comb begin
        case (dreq.wmask)
            SIZE_B:  ram_wdata = {4{dreq.wdata[7:0]}};
            SIZE_H:  ram_wdata = {2{dreq.wdata[15:0]}};
            default: ram_wdata = dreq.wdata;
        endcase
    end

    assign ram_en   = accept;
    assign ram_we   = (accept && dreq.wen) ? lane_mask : '0;
    assign ram_addr = dreq.addr[RAM_AW+1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            load_busy  <= 1'b0;
            lat_cnt    <= '0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;   // single-cycle pulse
            if (load_accept) begin
                load_busy <= 1'b1;
                lat_cnt   <= LAT_W'(LOAD_LATENCY - 1);
            end else if (load_done) begin
                load_busy  <= 1'b0;
                resp_valid <= 1'b1;
            end else if (load_busy) begin
                lat_cnt <= lat_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_accept) begin
            load_off <= byte_off;
        end
        // RAM word shifted down to bit 0, extension happens in the stage
        if (load_done) begin
            resp_rdata <= ram_rdata >> {load_off, 3'b000};
        end
    end

endmodule

// File: memory_stage.sv
`timescale 1ns/1ns

module memory_stage import mem_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    // from the execute stage
    input  logic      mem_valid,
    input  iid_t      mem_inst_id,
    input  mem_ctrl_t mem_ctrl,
    input  uint_x     mem_alu_out,
    input  uint_x     mem_rs2_data,

    // to writeback
    output logic      mem_wb_valid,
    output iid_t      mem_wb_inst_id,
    output mem_ctrl_t mem_wb_ctrl,
    output uint_x     mem_wb_alu_out,
    output uint_x     mem_wb_mem_rdata,

    output logic      memory_unit_stall,

    // memory unit
    data_req_if.stage dreq,
    input  logic      resp_valid,
    input  uint_x     resp_rdata
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_READY,
        WAIT_VALID
    } state_t;

    state_t   state;
    logic     executed;        // current instruction already done
    iid_t     saved_inst_id;
    uint_x    saved_rdata;     // raw load data from the unit
    mem_sel_t mem_wen;
    logic     may_start;
    logic     is_store;

    // a bubble looks like no access
    assign mem_wen = mem_valid ? mem_ctrl.mem_wen : MEN_X;
    assign is_store = (mem_wen == MEN_S);

    // held instruction that already finished must not go out again
    assign may_start = !executed || (saved_inst_id != mem_inst_id);

    assign dreq.valid = (state == WAIT_READY) && (mem_wen != MEN_X);
    assign dreq.wen   = is_store;
    assign dreq.addr  = mem_alu_out;
    assign dreq.wdata = mem_rs2_data;
    assign dreq.wmask = mem_ctrl.mem_size;

    // raised already in the cycle a new access shows up
    assign memory_unit_stall = (mem_wen != MEN_X) && ((state != IDLE) || may_start);

    // sign or zero extension of the loaded value
    function automatic uint_x extend_rdata(
        input mem_sel_t  sel,
        input mem_size_t size,
        input uint_x     raw
    );
        uint_x res;
        if (sel == MEN_LS) begin
            case (size)
                SIZE_B:  res = {{24{raw[7]}}, raw[7:0]};     // lb
                SIZE_H:  res = {{16{raw[15]}}, raw[15:0]};   // lh
                default: res = raw;                          // lw
            endcase
        end else begin
            case (size)
                SIZE_B:  res = {24'b0, raw[7:0]};    // lbu
                SIZE_H:  res = {16'b0, raw[15:0]};   // lhu
                default: res = raw;
            endcase
        end
        return res;
    endfunction

    assign mem_wb_valid     = mem_valid;
    assign mem_wb_inst_id   = mem_inst_id;
    assign mem_wb_ctrl      = mem_ctrl;
    assign mem_wb_alu_out   = mem_alu_out;
    assign mem_wb_mem_rdata = extend_rdata(mem_ctrl.mem_wen, mem_ctrl.mem_size, saved_rdata);

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= IDLE;
            executed      <= 1'b0;
            saved_inst_id <= IID_RANDOM;
        end else begin
            if (mem_valid) begin
                saved_inst_id <= mem_inst_id;
            end
            if (mem_wen == MEN_X) begin
                state    <= IDLE;
                executed <= 1'b0;
            end else begin
                case (state)
                    IDLE: begin
                        if (may_start) begin
                            state    <= WAIT_READY;
                            executed <= 1'b0;   // new instruction
                        end
                    end
                    WAIT_READY: begin
                        if (dreq.ready) begin
                            if (is_store) begin
                                state    <= IDLE;   // no response for stores
                                executed <= 1'b1;
                            end else begin
                                state <= WAIT_VALID;
                            end
                        end
                    end
                    WAIT_VALID: begin
                        if (resp_valid) begin
                            state    <= IDLE;
                            executed <= 1'b1;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // capture load data on the response pulse
    always_ff @(posedge clk) begin
        if (state == WAIT_VALID && resp_valid) begin
            saved_rdata <= resp_rdata;
        end
    end

endmodule

// File: mem_subsystem_top.sv
`timescale 1ns/1ns

module mem_subsystem_top import mem_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    input  logic      mem_valid,
    input  iid_t      mem_inst_id,
    input  mem_ctrl_t mem_ctrl,
    input  uint_x     mem_alu_out,
    input  uint_x     mem_rs2_data,

    output logic      mem_wb_valid,
    output iid_t      mem_wb_inst_id,
    output mem_ctrl_t mem_wb_ctrl,
    output uint_x     mem_wb_alu_out,
    output uint_x     mem_wb_mem_rdata,
    output logic      memory_unit_stall
);

    data_req_if dreq ();

    logic                 resp_valid;
    uint_x                resp_rdata;
    logic                 ram_en;
    logic [NUM_LANES-1:0] ram_we;
    logic [RAM_AW-1:0]    ram_addr;
    uint_x                ram_wdata;
    uint_x                ram_rdata;

    memory_stage u_stage (
        .clk               (clk),
        .rst               (rst),
        .mem_valid         (mem_valid),
        .mem_inst_id       (mem_inst_id),
        .mem_ctrl          (mem_ctrl),
        .mem_alu_out       (mem_alu_out),
        .mem_rs2_data      (mem_rs2_data),
        .mem_wb_valid      (mem_wb_valid),
        .mem_wb_inst_id    (mem_wb_inst_id),
        .mem_wb_ctrl       (mem_wb_ctrl),
        .mem_wb_alu_out    (mem_wb_alu_out),
        .mem_wb_mem_rdata  (mem_wb_mem_rdata),
        .memory_unit_stall (memory_unit_stall),
        .dreq              (dreq.stage),
        .resp_valid        (resp_valid),
        .resp_rdata        (resp_rdata)
    );

    memory_unit u_unit (
        .clk        (clk),
        .rst        (rst),
        .dreq       (dreq.unit),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .ram_en     (ram_en),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata),
        .ram_rdata  (ram_rdata)
    );

    data_ram u_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

// File: tb_mem_subsystem.sv
`timescale 1ns/1ns

module tb_mem_subsystem import mem_pkg::*; ();

    localparam int MAX_CYCLES = 4000;   // ~450 ops, up to 6 cycles each, plus margin
    localparam int NUM_BYTES = RAM_DEPTH * 4;

    logic      clk;
    logic      rst;
    logic      mem_valid;
    iid_t      mem_inst_id;
    mem_ctrl_t mem_ctrl;
    uint_x     mem_alu_out;
    uint_x     mem_rs2_data;
    logic      mem_wb_valid;
    iid_t      mem_wb_inst_id;
    mem_ctrl_t mem_wb_ctrl;
    uint_x     mem_wb_alu_out;
    uint_x     mem_wb_mem_rdata;
    logic      memory_unit_stall;

    // byte-wide copy of the data RAM
    logic [7:0] shadow [NUM_BYTES];
    bit         written [NUM_BYTES];

    iid_t  next_id = 8'd1;
    int    drv_errors = 0;
    int    chk_errors = 0;
    int    checks = 0;
    int    cycles = 0;
    string test_name = "reset";
    logic  check_en = 1'b0;   // load result expected while stall is low
    uint_x exp_data = '0;

    mem_subsystem_top DUT (
        .clk               (clk),
        .rst               (rst),
        .mem_valid         (mem_valid),
        .mem_inst_id       (mem_inst_id),
        .mem_ctrl          (mem_ctrl),
        .mem_alu_out       (mem_alu_out),
        .mem_rs2_data      (mem_rs2_data),
        .mem_wb_valid      (mem_wb_valid),
        .mem_wb_inst_id    (mem_wb_inst_id),
        .mem_wb_ctrl       (mem_wb_ctrl),
        .mem_wb_alu_out    (mem_wb_alu_out),
        .mem_wb_mem_rdata  (mem_wb_mem_rdata),
        .memory_unit_stall (memory_unit_stall)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    function automatic void report_value(input string what, input uint_x exp, input uint_x act);
        $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
    endfunction

    // expected load result, little endian, lb/lbu/lh/lhu/lw rules
    function automatic uint_x exp_load(input int addr, input mem_size_t size, input bit sgn);
        uint_x res;
        case (size)
            SIZE_B: begin
                res = {24'h0, shadow[addr]};
                if (sgn && res[7]) res[31:8] = 24'hffffff;
            end
            SIZE_H: begin
                res = {16'h0, shadow[addr + 1], shadow[addr]};
                if (sgn && res[15]) res[31:16] = 16'hffff;
            end
            default: res = {shadow[addr + 3], shadow[addr + 2], shadow[addr + 1], shadow[addr]};
        endcase
        return res;
    endfunction

    function automatic int size_bytes(input mem_size_t size);
        return (size == SIZE_B) ? 1 : (size == SIZE_H) ? 2 : 4;
    endfunction

    function automatic bit fully_written(input int addr, input mem_size_t size);
        bit ok;
        ok = 1'b1;
        for (int i = 0; i < size_bytes(size); i++) begin
            if (!written[addr + i]) ok = 1'b0;
        end
        return ok;
    endfunction

    task automatic shadow_store(input int addr, input mem_size_t size, input uint_x data);
        for (int i = 0; i < size_bytes(size); i++) begin
            shadow[addr + i] = data[8*i +: 8];
            written[addr + i] = 1'b1;
        end
    endtask

    task automatic check_passthru();
        if (mem_wb_valid !== mem_valid) begin
            drv_errors++;
            report_value("wb valid", uint_x'(mem_valid), uint_x'(mem_wb_valid));
        end
        if (mem_wb_inst_id !== mem_inst_id) begin
            drv_errors++;
            report_value("wb inst_id", uint_x'(mem_inst_id), uint_x'(mem_wb_inst_id));
        end
        if (mem_wb_ctrl !== mem_ctrl) begin
            drv_errors++;
            report_value("wb ctrl", uint_x'(mem_ctrl), uint_x'(mem_wb_ctrl));
        end
        if (mem_wb_alu_out !== mem_alu_out) begin
            drv_errors++;
            report_value("wb alu_out", mem_alu_out, mem_wb_alu_out);
        end
    endtask

    // present one instruction, wait out the stall, then hold it for extra cycles
    task automatic run_op(input bit vbit, input mem_sel_t sel, input mem_size_t size,
                          input int addr, input uint_x wdata, input int hold);
        int stalled;
        int want;
        @(negedge clk);
        mem_valid = vbit;
        mem_inst_id = next_id;
        mem_ctrl.mem_wen = sel;
        mem_ctrl.mem_size = size;
        mem_alu_out = uint_x'(addr);
        mem_rs2_data = wdata;
        next_id = next_id + 8'd1;
        check_en = 1'b0;
        want = 0;
        if (vbit && sel == MEN_S) begin
            shadow_store(addr, size, wdata);
            want = 2;
        end else if (vbit && sel != MEN_X) begin
            exp_data = exp_load(addr, size, sel == MEN_LS);
            check_en = 1'b1;
            want = 4;
        end
        stalled = 0;
        #1;
        check_passthru();
        while (memory_unit_stall && stalled < 16) begin
            stalled++;
            @(negedge clk);
            #1;
        end
        if (stalled != want) begin
            drv_errors++;
            report_value("stall cycles", uint_x'(want), uint_x'(stalled));
        end
        repeat (hold) begin
            @(negedge clk);
            #1;
            if (memory_unit_stall) begin
                drv_errors++;
                $display("%s: stall came back for a held instruction %h", test_name, mem_inst_id);
            end
        end
    endtask

    // compares load data in every cycle with stall low
    always @(negedge clk) begin
        #1;
        if (check_en && !memory_unit_stall) begin
            checks++;
            if (mem_wb_mem_rdata !== exp_data) begin
                chk_errors++;
                report_value("load data", exp_data, mem_wb_mem_rdata);
            end
        end
    end

    initial begin
        int seed_init;
        int w;
        int off;
        int a;
        mem_size_t size;
        mem_sel_t sel;
        seed_init = $urandom(32'hc763);
        rst = 1'b1;
        mem_valid = 1'b0;
        mem_inst_id = 8'd0;
        mem_ctrl.mem_wen = MEN_X;
        mem_ctrl.mem_size = SIZE_W;
        mem_alu_out = '0;
        mem_rs2_data = '0;
        for (int i = 0; i < NUM_BYTES; i++) written[i] = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_name = "word_round_trip";
        for (w = 0; w < 32; w++) run_op(1'b1, MEN_S, SIZE_W, w * 4, $urandom(), 0);
        for (w = 0; w < 32; w++) run_op(1'b1, MEN_LS, SIZE_W, w * 4, '0, 0);

        test_name = "partial_store";
        for (int i = 0; i < 16; i++) begin
            w = $urandom_range(31, 0);
            if (i % 2 == 1) begin
                off = 2 * $urandom_range(1, 0);
                run_op(1'b1, MEN_S, SIZE_H, w * 4 + off, $urandom(), 0);
            end else begin
                off = $urandom_range(3, 0);
                run_op(1'b1, MEN_S, SIZE_B, w * 4 + off, $urandom(), 0);
            end
            run_op(1'b1, MEN_LS, SIZE_W, w * 4, '0, 0);   // merged word
        end

        test_name = "load_extension";
        run_op(1'b1, MEN_S, SIZE_W, 160, 32'h807fff01, 0);   // mixed top bits
        run_op(1'b1, MEN_S, SIZE_W, 164, 32'h7f8001fe, 0);
        for (a = 160; a < 168; a++) begin
            run_op(1'b1, MEN_LS, SIZE_B, a, '0, 0);
            run_op(1'b1, MEN_LU, SIZE_B, a, '0, 0);
            if (a % 2 == 0) begin
                run_op(1'b1, MEN_LS, SIZE_H, a, '0, 0);
                run_op(1'b1, MEN_LU, SIZE_H, a, '0, 0);
            end
        end

        test_name = "stall_length";
        run_op(1'b1, MEN_S, SIZE_W, 200, 32'h13579bdf, 0);
        run_op(1'b1, MEN_LS, SIZE_W, 200, '0, 0);

        test_name = "no_reissue";
        run_op(1'b1, MEN_S, SIZE_H, 202, 32'h0000c3a5, 3);
        run_op(1'b1, MEN_LS, SIZE_H, 202, '0, 3);

        test_name = "bubbles";
        for (int i = 0; i < 6; i++) begin
            if (i % 2 == 1) run_op(1'b1, MEN_X, SIZE_W, 4 * i, $urandom(), 1);
            else run_op(1'b0, MEN_LS, SIZE_W, 4 * i, $urandom(), 1);   // load ctrl, no valid
        end

        test_name = "random_mix";
        for (int i = 0; i < 350; i++) begin
            w = $urandom_range(63, 0);
            case ($urandom_range(2, 0))
                0: begin
                    size = SIZE_B;
                    off = $urandom_range(3, 0);
                end
                1: begin
                    size = SIZE_H;
                    off = 2 * $urandom_range(1, 0);
                end
                default: begin
                    size = SIZE_W;
                    off = 0;
                end
            endcase
            a = w * 4 + off;
            if ($urandom_range(1, 0) == 1 && fully_written(a, size)) begin
                sel = ($urandom_range(1, 0) == 1 || size == SIZE_W) ? MEN_LS : MEN_LU;
                run_op(1'b1, sel, size, a, '0, 0);
            end else begin
                run_op(1'b1, MEN_S, size, a, $urandom(), 0);
            end
            if (i % 25 == 0) run_op(1'b0, MEN_S, SIZE_W, a, $urandom(), 0);
        end

        @(negedge clk);
        mem_valid = 1'b0;
        check_en = 1'b0;
        repeat (2) @(negedge clk);
        $display("load checks: %0d, driver errors: %0d, checker errors: %0d",
                 checks, drv_errors, chk_errors);
        if (drv_errors == 0 && chk_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: sources.f
mem_pkg.sv
data_req_if.sv
data_ram.sv
memory_unit.sv
memory_stage.sv
mem_subsystem_top.sv
tb_mem_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_mem_subsystem -f sources.f -o tb_mem_subsystem
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/tb_mem_subsystem)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench prints the pass line only when every check held
if echo "$out" | grep -qx "No errors"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi
